/* design/fetch_pkg.sv */
package fetch_pkg;

	// --------------------------------------------------
	// Sizes and reset values
	// --------------------------------------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] instr_t;

	localparam addr_t RESET_PC = 32'h0000_0100;

	// Delay stages behind the fetch stage register
	localparam int FETCH_DEPTH = 4;

	// Direct mapped BTB, index from PC[5:2], tag from PC[31:6]
	localparam int BTB_ENTRIES = 16;
	localparam int BTB_INDEX_BITS = 4;
	localparam int BTB_TAG_BITS = 26;

	// Two bit saturating counter, MSB set means predict taken
	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,
		weak_not_taken   = 2'b01,
		weak_taken       = 2'b10,
		strong_taken     = 2'b11
	} pred_state_e;

	// --------------------------------------------------
	// Stage payloads
	// --------------------------------------------------
	typedef struct packed {
		logic  taken;
		addr_t target;
	} prediction_t;

	typedef struct packed {
		logic        valid;
		addr_t       pc;
		instr_t      instr;
		prediction_t pred;
	} fetch_slot_t;

	// Actual outcome from decode for the slot at fetch_out
	typedef struct packed {
		logic  is_branch;
		logic  taken;
		addr_t target;
	} resolve_t;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		logic  taken;
		addr_t target;
	} train_t;

endpackage

/* design/pc_gen.sv */
`timescale 1ns/1ns

module pc_gen (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  logic                  redirect,
	input  fetch_pkg::addr_t      redirect_pc,
	input  fetch_pkg::prediction_t pred,
	output fetch_pkg::addr_t      pc
);

	import fetch_pkg::*;

	addr_t pc_reg;
	addr_t next_pc;

	// Redirect beats stall, stall beats prediction
	always_comb begin
		if (redirect) begin
			next_pc = redirect_pc;
		end else if (stall) begin
			next_pc = pc_reg;
		end else if (pred.taken) begin
			next_pc = pred.target;
		end else begin
			next_pc = pc_reg + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_reg <= RESET_PC;
		end else begin
			pc_reg <= next_pc;
		end
	end

	// Current PC doubles as instruction memory address
	assign pc = pc_reg;

endmodule

/* design/branch_predictor.sv */
`timescale 1ns/1ns

module branch_predictor (
	input  logic                   clk,
	input  logic                   reset,
	input  fetch_pkg::addr_t       lookup_pc,
	output fetch_pkg::prediction_t pred,
	input  fetch_pkg::train_t      train
);

	import fetch_pkg::*;

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	logic [BTB_ENTRIES-1:0] btb_valid;
	logic [BTB_TAG_BITS-1:0] btb_tag [BTB_ENTRIES];
	addr_t btb_target [BTB_ENTRIES];
	pred_state_e counter [BTB_ENTRIES];

	logic [BTB_INDEX_BITS-1:0] rd_index;
	logic [BTB_TAG_BITS-1:0] rd_tag;
	logic rd_hit;

	logic [BTB_INDEX_BITS-1:0] wr_index;
	logic [BTB_TAG_BITS-1:0] wr_tag;
	logic wr_hit;

	// Saturating step toward the outcome
	function automatic pred_state_e next_state(pred_state_e cur, logic taken);
		pred_state_e nxt;
		case (cur)
			strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
			weak_not_taken:   nxt = taken ? weak_taken : strong_not_taken;
			weak_taken:       nxt = taken ? strong_taken : weak_not_taken;
			default:          nxt = taken ? strong_taken : weak_taken;
		endcase
		return nxt;
	endfunction

	// --------------------------------------------------
	// Lookup
	// --------------------------------------------------
	assign rd_index = lookup_pc[BTB_INDEX_BITS+1:2];
	assign rd_tag = lookup_pc[31 -: BTB_TAG_BITS];
	assign rd_hit = btb_valid[rd_index] && (btb_tag[rd_index] == rd_tag);

	// Counter MSB set for weak_taken and strong_taken
	assign pred.taken = rd_hit && counter[rd_index][1];
	assign pred.target = btb_target[rd_index];

	// --------------------------------------------------
	// Training
	// --------------------------------------------------
	assign wr_index = train.pc[BTB_INDEX_BITS+1:2];
	assign wr_tag = train.pc[31 -: BTB_TAG_BITS];
	assign wr_hit = btb_valid[wr_index] && (btb_tag[wr_index] == wr_tag);

	always_ff @(posedge clk) begin
		if (reset) begin
			btb_valid <= '0;
			for (int i = 0; i < BTB_ENTRIES; i++) begin
				counter[i] <= weak_not_taken;
			end
		end else if (train.valid) begin
			if (train.taken) begin
				btb_valid[wr_index] <= 1'b1;
				counter[wr_index] <= next_state(counter[wr_index], 1'b1);
			end else if (wr_hit) begin
				counter[wr_index] <= next_state(counter[wr_index], 1'b0);
			end
		end
	end

	// Tag and target only change on taken outcomes
	always_ff @(posedge clk) begin
		if (train.valid && train.taken) begin
			btb_tag[wr_index] <= wr_tag;
			btb_target[wr_index] <= train.target;
		end
	end

endmodule

/* design/fetch_delay_line.sv */
`timescale 1ns/1ns

module fetch_delay_line (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	input  logic                   flush,
	input  fetch_pkg::addr_t       fetch_pc,
	input  fetch_pkg::instr_t      fetch_instr,
	input  fetch_pkg::prediction_t fetch_pred,
	output fetch_pkg::fetch_slot_t slot_out
);

	import fetch_pkg::*;

	// Stage 0 is the fetch register, the rest are delay stages
	fetch_slot_t stage_data [FETCH_DEPTH+1];

	// --------------------------------------------------
	// Capture and shift
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			for (int i = 0; i <= FETCH_DEPTH; i++) begin
				stage_data[i].valid <= 1'b0;
			end
		end else if (!stall) begin
			stage_data[0].valid <= 1'b1;
			stage_data[0].pc <= fetch_pc;
			stage_data[0].instr <= fetch_instr;
			stage_data[0].pred <= fetch_pred;
			for (int i = 1; i <= FETCH_DEPTH; i++) begin
				stage_data[i] <= stage_data[i-1];
			end
		end
	end

	// Oldest slot goes to decode
	assign slot_out = stage_data[FETCH_DEPTH];

endmodule

/* design/branch_resolver.sv */
`timescale 1ns/1ns

module branch_resolver (
	input  logic                   stall,
	input  fetch_pkg::fetch_slot_t slot,
	input  fetch_pkg::resolve_t    resolve,
	output logic                   redirect,
	output fetch_pkg::addr_t       redirect_pc,
	output fetch_pkg::train_t      train
);

	import fetch_pkg::*;

	logic active;
	logic mispredict;

	// Decode outcome only counts for a live slot that advances
	assign active = slot.valid && !stall;

	// --------------------------------------------------
	// Misprediction check
	// --------------------------------------------------
	always_comb begin
		if (resolve.is_branch) begin
			mispredict = (resolve.taken != slot.pred.taken) ||
				(resolve.taken && slot.pred.taken &&
				(resolve.target != slot.pred.target));
		end else begin
			// Stale BTB hit on a non-branch
			mispredict = slot.pred.taken;
		end
	end

	assign redirect = active && mispredict;

	// No delay slot, fall through is the next word
	always_comb begin
		if (resolve.is_branch && resolve.taken) begin
			redirect_pc = resolve.target;
		end else begin
			redirect_pc = slot.pc + 32'd4;
		end
	end

	// --------------------------------------------------
	// Training request
	// --------------------------------------------------
	always_comb begin
		train.valid = active && resolve.is_branch;
		train.pc = slot.pc;
		train.taken = resolve.taken;
		train.target = resolve.target;
	end

endmodule

/* design/fetch_frontend.sv */
`timescale 1ns/1ns

module fetch_frontend (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	output fetch_pkg::addr_t       imem_addr,
	input  fetch_pkg::instr_t      imem_data,
	output fetch_pkg::fetch_slot_t fetch_out,
	input  fetch_pkg::resolve_t    resolve,
	output logic                   redirect
);

	import fetch_pkg::*;

	// Between blocks
	prediction_t pred;
	addr_t redirect_pc;
	train_t train;

	// --------------------------------------------------
	// Fetch address and prediction
	// --------------------------------------------------
	pc_gen pc_gen (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.pred(pred),
		.pc(imem_addr)
	);

	branch_predictor branch_predictor (
		.clk(clk),
		.reset(reset),
		.lookup_pc(imem_addr),
		.pred(pred),
		.train(train)
	);

	// --------------------------------------------------
	// Delay chain down to decode
	// --------------------------------------------------
	fetch_delay_line fetch_delay_line (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(redirect),
		.fetch_pc(imem_addr),
		.fetch_instr(imem_data),
		.fetch_pred(pred),
		.slot_out(fetch_out)
	);

	// Check at the end of the chain
	branch_resolver branch_resolver (
		.stall(stall),
		.slot(fetch_out),
		.resolve(resolve),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.train(train)
	);

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	// 20 ns period
	localparam int HALF_PERIOD = 10;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

/* verification/fetch_frontend_props.sv */
`timescale 1ns/1ns

module fetch_frontend_props (
	input logic                   clk,
	input logic                   reset,
	input logic                   stall,
	input logic                   redirect,
	input fetch_pkg::fetch_slot_t fetch_out
);

	// Chain is empty right after reset
	assert property (@(posedge clk) reset |=> !fetch_out.valid)
		else $error("fetch_out valid in the cycle after reset");

	// Flush clears every stage
	assert property (@(posedge clk) disable iff (reset) redirect |=> !fetch_out.valid)
		else $error("fetch_out valid in the cycle after redirect");

	assert property (@(posedge clk) disable iff (reset)
		(stall && !redirect) |=> $stable(fetch_out))
		else $error("fetch_out changed while stalled");

endmodule

bind fetch_frontend fetch_frontend_props props (
	.clk(clk),
	.reset(reset),
	.stall(stall),
	.redirect(redirect),
	.fetch_out(fetch_out)
);

/* verification/tb_fetch_frontend.sv */
`timescale 1ns/1ns

module tb_fetch_frontend;

	import fetch_pkg::*;

	localparam logic [31:0] SEED = 32'h0ab91067;
	localparam int IMEM_WORDS = 64;
	localparam int NUM_ROWS = 14;
	localparam int RESET_CYCLES = 4;
	localparam int ROW_BUDGET = FETCH_DEPTH + 12;
	localparam int TIMEOUT_CYCLES = 2 * NUM_ROWS * ROW_BUDGET + RESET_CYCLES;

	// Decode table row
	// Bit i of stall_mask stalls cycle i of the row
	typedef struct packed {
		addr_t      pc;
		logic       is_branch;
		logic       taken;
		addr_t      target;
		logic [7:0] stall_mask;
		logic       exp_pred;
		logic       exp_redirect;
	} row_t;

	// Fetch still in flight, with the prediction it got at fetch time
	typedef struct packed {
		addr_t       pc;
		prediction_t pred;
		int          stamp;
	} inflight_t;

	logic clk;
	logic reset;
	logic stall;
	addr_t imem_addr;
	instr_t imem_data;
	fetch_slot_t fetch_out;
	resolve_t resolve;
	logic redirect;

	instr_t imem [IMEM_WORDS];
	row_t rows [NUM_ROWS];
	inflight_t inflight [$];

	// Predictor reference state
	logic model_valid [BTB_ENTRIES];
	logic [BTB_TAG_BITS-1:0] model_tag [BTB_ENTRIES];
	addr_t model_target [BTB_ENTRIES];
	int model_count [BTB_ENTRIES];

	int error_count = 0;
	int cycle_count = 0;
	int adv_count = 0;
	addr_t exp_fetch_pc;
	addr_t exp_path_pc;
	logic prev_stall;
	fetch_slot_t held_out;

	tb_clock clock_gen (.clk(clk));

	fetch_frontend dut (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.fetch_out(fetch_out),
		.resolve(resolve),
		.redirect(redirect)
	);

	// Instruction memory answers in the same cycle
	assign imem_data = imem[imem_addr[7:2]];

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles, a table row never reached fetch_out", cycle_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic report_error(string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_problem(string msg);
		$display("At %0t ns: %s", $time, msg);
		error_count++;
	endtask

	// --------------------------------------------------
	// Predictor reference model
	// --------------------------------------------------
	function automatic logic model_taken(addr_t pc);
		logic [BTB_INDEX_BITS-1:0] idx;
		idx = pc[5:2];
		return model_valid[idx] && (model_tag[idx] == pc[31:6]) && (model_count[idx] >= 2);
	endfunction

	task automatic train_model(addr_t pc, logic taken, addr_t target);
		logic [BTB_INDEX_BITS-1:0] idx;
		logic hit;
		idx = pc[5:2];
		hit = model_valid[idx] && (model_tag[idx] == pc[31:6]);
		if (taken) begin
			if (model_count[idx] < 3) begin
				model_count[idx]++;
			end
			model_valid[idx] = 1'b1;
			model_tag[idx] = pc[31:6];
			model_target[idx] = target;
		end else if (hit && model_count[idx] > 0) begin
			model_count[idx]--;
		end
	endtask

	task automatic load_table();
		rows[0]  = '{32'h0000_0100, 1'b0, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0};
		rows[1]  = '{32'h0000_010c, 1'b0, 1'b0, 32'h0, 8'h1e, 1'b0, 1'b0};
		rows[2]  = '{32'h0000_0118, 1'b1, 1'b1, 32'h0000_0140, 8'h00, 1'b0, 1'b1};
		// Same index as 0x118, other tag
		rows[3]  = '{32'h0000_0158, 1'b0, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0};
		rows[4]  = '{32'h0000_0160, 1'b1, 1'b1, 32'h0000_0118, 8'h00, 1'b0, 1'b1};
		rows[5]  = '{32'h0000_0118, 1'b1, 1'b1, 32'h0000_0140, 8'h00, 1'b1, 1'b0};
		rows[6]  = '{32'h0000_0160, 1'b1, 1'b1, 32'h0000_0118, 8'h00, 1'b1, 1'b0};
		rows[7]  = '{32'h0000_0118, 1'b1, 1'b1, 32'h0000_0140, 8'h03, 1'b1, 1'b0};
		rows[8]  = '{32'h0000_0160, 1'b1, 1'b1, 32'h0000_0118, 8'h00, 1'b1, 1'b0};
		rows[9]  = '{32'h0000_0118, 1'b1, 1'b0, 32'h0000_0140, 8'h00, 1'b1, 1'b1};
		rows[10] = '{32'h0000_0160, 1'b1, 1'b1, 32'h0000_0118, 8'h00, 1'b1, 1'b0};
		rows[11] = '{32'h0000_0118, 1'b1, 1'b0, 32'h0000_0140, 8'h00, 1'b1, 1'b1};
		rows[12] = '{32'h0000_0160, 1'b1, 1'b1, 32'h0000_0118, 8'h00, 1'b1, 1'b0};
		// Counter stepped down twice, now predicted not taken
		rows[13] = '{32'h0000_0118, 1'b1, 1'b0, 32'h0000_0140, 8'h00, 1'b0, 1'b0};
	endtask

	task automatic drive_inputs(row_t row, int cyc);
		stall = (cyc < 8) ? row.stall_mask[cyc[2:0]] : 1'b0;
		resolve = '0;
		if (fetch_out.valid && fetch_out.pc == row.pc) begin
			resolve.is_branch = row.is_branch;
			resolve.taken = row.taken;
			resolve.target = row.target;
		end
	endtask

	// --------------------------------------------------
	// Per cycle checks sampled mid cycle
	// --------------------------------------------------
	task automatic check_cycle();
		prediction_t fetch_pred;
		inflight_t head;
		logic exp_redirect;
		logic mispredict;
		addr_t actual_next;
		head = '0;
		exp_redirect = 1'b0;
		actual_next = '0;
		fetch_pred.taken = model_taken(imem_addr);
		fetch_pred.target = model_target[imem_addr[5:2]];
		if (imem_addr !== exp_fetch_pc) begin
			report_error($sformatf("imem_addr %h, expected %h", imem_addr, exp_fetch_pc));
		end
		if (stall) begin
			if (prev_stall && fetch_out !== held_out) begin
				report_error("fetch_out changed while stalled");
			end
			if (redirect !== 1'b0) begin
				report_error("redirect high while stalled");
			end
		end else begin
			if (fetch_out.valid) begin
				if (inflight.size() == 0) begin
					report_problem($sformatf("slot %h left the chain but was never fetched",
						fetch_out.pc));
				end else begin
					head = inflight.pop_front();
				end
				if (fetch_out.pc !== head.pc || fetch_out.pc !== exp_path_pc) begin
					report_error($sformatf("slot pc %h, expected %h", fetch_out.pc, exp_path_pc));
				end
				if (adv_count - head.stamp != FETCH_DEPTH + 1) begin
					report_error($sformatf("slot latency %0d", adv_count - head.stamp));
				end
				if (fetch_out.instr !== imem[exp_path_pc[7:2]]) begin
					report_error($sformatf("instr %h at pc %h", fetch_out.instr, fetch_out.pc));
				end
				if (fetch_out.pred.taken !== head.pred.taken ||
					(head.pred.taken && fetch_out.pred.target !== head.pred.target)) begin
					report_error($sformatf("prediction mismatch at pc %h", fetch_out.pc));
				end
				if (resolve.is_branch) begin
					actual_next = resolve.taken ? resolve.target : fetch_out.pc + 32'd4;
					mispredict = (resolve.taken != head.pred.taken) ||
						(resolve.taken && head.pred.taken && resolve.target != head.pred.target);
					train_model(fetch_out.pc, resolve.taken, resolve.target);
				end else begin
					actual_next = fetch_out.pc + 32'd4;
					mispredict = head.pred.taken;
				end
				exp_redirect = mispredict;
				exp_path_pc = actual_next;
			end else if (inflight.size() > 0 && adv_count - inflight[0].stamp >= FETCH_DEPTH + 1) begin
				report_problem($sformatf("fetched pc %h was lost in the chain", inflight[0].pc));
				void'(inflight.pop_front());
			end
			if (redirect !== exp_redirect) begin
				report_error($sformatf("redirect %b, expected %b", redirect, exp_redirect));
			end
			if (exp_redirect) begin
				inflight.delete();
				exp_fetch_pc = actual_next;
			end else begin
				head.pc = imem_addr;
				head.pred = fetch_pred;
				head.stamp = adv_count;
				inflight.push_back(head);
				exp_fetch_pc = fetch_pred.taken ? fetch_pred.target : imem_addr + 32'd4;
			end
			adv_count++;
		end
		prev_stall = stall;
		held_out = fetch_out;
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int errors_before;
		int row_cycle;
		int rows_passed;
		int rows_failed;
		logic found;
		reset = 1'b1;
		stall = 1'b0;
		resolve = '0;
		rows_passed = 0;
		rows_failed = 0;
		void'($urandom(SEED));
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = $urandom();
		end
		for (int i = 0; i < BTB_ENTRIES; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i] = '0;
			model_target[i] = '0;
			model_count[i] = 1;
		end
		load_table();
		exp_fetch_pc = RESET_PC;
		exp_path_pc = RESET_PC;
		prev_stall = 1'b0;
		held_out = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			errors_before = error_count;
			row_cycle = 0;
			found = 1'b0;
			while (!found) begin
				drive_inputs(rows[r], row_cycle);
				#8;
				check_cycle();
				if (fetch_out.valid && !stall && fetch_out.pc == rows[r].pc) begin
					found = 1'b1;
					if (fetch_out.pred.taken !== rows[r].exp_pred) begin
						report_error($sformatf("row %0d pred.taken %b", r, fetch_out.pred.taken));
					end
					if (redirect !== rows[r].exp_redirect) begin
						report_error($sformatf("row %0d redirect %b", r, redirect));
					end
				end
				row_cycle++;
				@(posedge clk);
				#2;
			end
			if (error_count == errors_before) begin
				rows_passed++;
				$display("Row %0d pc %h: ok after %0d cycles", r, rows[r].pc, row_cycle);
			end else begin
				rows_failed++;
				$display("Row %0d pc %h: %0d errors", r, rows[r].pc, error_count - errors_before);
			end
		end

		$display("Rows passed %0d, rows failed %0d, errors %0d",
			rows_passed, rows_failed, error_count);
		if (error_count == 0 && rows_failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* list.f */
design/fetch_pkg.sv
design/pc_gen.sv
design/branch_predictor.sv
design/fetch_delay_line.sv
design/branch_resolver.sv
design/fetch_frontend.sv
verification/tb_clock.sv
verification/fetch_frontend_props.sv
verification/tb_fetch_frontend.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_fetch_frontend -f list.f -o tb_fetch_frontend &&
	./obj_dir/tb_fetch_frontend | tee sim.log ||
	echo "Build or simulation did not complete"
grep -qF '*** TEST PASSED ***' sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
